//--- source/rv_pkg.sv
package rv_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	parameter int XLEN   = 32;
	parameter int REG_AW = 5;

	// --------------------------------------------------
	// opcodes, subset only
	// --------------------------------------------------
	parameter logic [6:0] OP_REG    = 7'b0110011;
	parameter logic [6:0] OP_IMM    = 7'b0010011;
	parameter logic [6:0] OP_BRANCH = 7'b1100011;
	parameter logic [6:0] OP_JAL    = 7'b1101111;
	parameter logic [6:0] OP_LOAD   = 7'b0000011;
	parameter logic [6:0] OP_STORE  = 7'b0100011;

	// alu funct3
	parameter logic [2:0] F3_ADD  = 3'b000;
	parameter logic [2:0] F3_SLL  = 3'b001;
	parameter logic [2:0] F3_SLT  = 3'b010;
	parameter logic [2:0] F3_SLTU = 3'b011;
	parameter logic [2:0] F3_XOR  = 3'b100;
	parameter logic [2:0] F3_SR   = 3'b101;
	parameter logic [2:0] F3_OR   = 3'b110;
	parameter logic [2:0] F3_AND  = 3'b111;

	// branch funct3
	parameter logic [2:0] F3_BEQ  = 3'b000;
	parameter logic [2:0] F3_BNE  = 3'b001;
	parameter logic [2:0] F3_BLT  = 3'b100;
	parameter logic [2:0] F3_BGE  = 3'b101;
	parameter logic [2:0] F3_BLTU = 3'b110;
	parameter logic [2:0] F3_BGEU = 3'b111;

	// --------------------------------------------------
	// instruction formats, msb first
	// --------------------------------------------------
	typedef struct packed {
		logic [6:0]        funct7;
		logic [REG_AW-1:0] rs2;
		logic [REG_AW-1:0] rs1;
		logic [2:0]        funct3;
		logic [REG_AW-1:0] rd;
		logic [6:0]        opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0]       imm_11_0;
		logic [REG_AW-1:0] rs1;
		logic [2:0]        funct3;
		logic [REG_AW-1:0] rd;
		logic [6:0]        opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0]        imm_11_5;
		logic [REG_AW-1:0] rs2;
		logic [REG_AW-1:0] rs1;
		logic [2:0]        funct3;
		logic [4:0]        imm_4_0;
		logic [6:0]        opcode;
	} s_fmt_t;

	// scrambled immediate, bit 0 implied zero
	typedef struct packed {
		logic              imm_12;
		logic [5:0]        imm_10_5;
		logic [REG_AW-1:0] rs2;
		logic [REG_AW-1:0] rs1;
		logic [2:0]        funct3;
		logic [3:0]        imm_4_1;
		logic              imm_11;
		logic [6:0]        opcode;
	} b_fmt_t;

	typedef struct packed {
		logic              imm_20;
		logic [9:0]        imm_10_1;
		logic              imm_11;
		logic [7:0]        imm_19_12;
		logic [REG_AW-1:0] rd;
		logic [6:0]        opcode;
	} j_fmt_t;

	// one word, read through whichever format the opcode selects
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		j_fmt_t j;
	} instr_u;

	// multi-cycle sequencer states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FETCH,
		ST_LATCH,
		ST_EXEC,
		ST_MEM,
		ST_WB,
		ST_DONE
	} ctrl_state_e;

endpackage

//--- source/rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
	input  rv_pkg::instr_u                instr,
	output logic [rv_pkg::REG_AW-1:0]     rs1_idx,
	output logic [rv_pkg::REG_AW-1:0]     rs2_idx,
	output logic [rv_pkg::REG_AW-1:0]     rd_idx,
	output logic [rv_pkg::XLEN-1:0]       imm
);

	always_comb
	begin
		// register-type layout unless overridden below
		rs1_idx = instr.r.rs1;
		rs2_idx = instr.r.rs2;
		rd_idx  = instr.r.rd;
		imm     = '0;

		case (instr.r.opcode)
			rv_pkg::OP_IMM:
			begin
				rs1_idx = instr.i.rs1;
				rd_idx  = instr.i.rd;
				// shifts only carry shamt, funct7 stays with the alu
				if (instr.i.funct3 == rv_pkg::F3_SLL || instr.i.funct3 == rv_pkg::F3_SR)
					imm = {{(rv_pkg::XLEN-5){1'b0}}, instr.i.imm_11_0[4:0]};
				else
					imm = {{(rv_pkg::XLEN-12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
			end

			rv_pkg::OP_LOAD:
			begin
				rs1_idx = instr.i.rs1;
				rd_idx  = instr.i.rd;
				imm     = {{(rv_pkg::XLEN-12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
			end

			rv_pkg::OP_STORE:
			begin
				rs1_idx = instr.s.rs1;
				rs2_idx = instr.s.rs2;
				// imm bits sit where rd would be
				rd_idx  = '0;
				imm     = {{(rv_pkg::XLEN-12){instr.s.imm_11_5[6]}},
					instr.s.imm_11_5, instr.s.imm_4_0};
			end

			rv_pkg::OP_BRANCH:
			begin
				rs1_idx = instr.b.rs1;
				rs2_idx = instr.b.rs2;
				rd_idx  = '0;
				imm     = {{(rv_pkg::XLEN-13){instr.b.imm_12}}, instr.b.imm_12,
					instr.b.imm_11, instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
			end

			rv_pkg::OP_JAL:
			begin
				rd_idx = instr.j.rd;
				imm    = {{(rv_pkg::XLEN-21){instr.j.imm_20}}, instr.j.imm_20,
					instr.j.imm_19_12, instr.j.imm_11, instr.j.imm_10_1, 1'b0};
			end

			// register ops and anything unknown need no immediate
			default:
				imm = '0;
		endcase
	end

endmodule

//--- source/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [rv_pkg::REG_AW-1:0]   rs1_idx,
	input  logic [rv_pkg::REG_AW-1:0]   rs2_idx,
	input  logic [rv_pkg::REG_AW-1:0]   rd_idx,
	input  logic                        we,
	input  logic [rv_pkg::XLEN-1:0]     wdata,
	output logic [rv_pkg::XLEN-1:0]     rs1_val,
	output logic [rv_pkg::XLEN-1:0]     rs2_val
);

	localparam int NREGS = 2**rv_pkg::REG_AW;

	// x0 included, never written after reset
	logic [rv_pkg::XLEN-1:0] regs [NREGS];

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int k = 0; k < NREGS; k++)
				regs[k] <= '0;
		end
		else if (we && rd_idx != '0)
		begin
			regs[rd_idx] <= wdata;
		end
	end

	// combinational read ports
	assign rs1_val = regs[rs1_idx];
	assign rs2_val = regs[rs2_idx];

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	// zero register holds zero across every write cycle
	a_x0_zero: assert property (
		@(posedge clk) disable iff (!rst)
		regs[0] == '0
	);

endmodule

//--- source/rv_alu.sv
`timescale 1ns/10ps

module rv_alu (
	input  rv_pkg::instr_u              instr,
	input  logic [rv_pkg::XLEN-1:0]     rs1_val,
	input  logic [rv_pkg::XLEN-1:0]     rs2_val,
	input  logic [rv_pkg::XLEN-1:0]     imm,
	output logic [rv_pkg::XLEN-1:0]     result,
	output logic                        branch_taken
);

	logic [rv_pkg::XLEN-1:0]         op_b;
	logic [$clog2(rv_pkg::XLEN)-1:0] shamt;
	logic                            alt;
	logic                            is_reg;
	logic signed [rv_pkg::XLEN-1:0]  sra_val;
	logic                            lt_s;
	logic                            lt_u;

	// second operand, imm for i-type, rs2 for reg ops and branches
	assign is_reg = (instr.r.opcode == rv_pkg::OP_REG);
	assign op_b   = (instr.r.opcode == rv_pkg::OP_IMM) ? imm : rs2_val;
	assign shamt  = op_b[$clog2(rv_pkg::XLEN)-1:0];

	// funct7 bit 5 selects sub and arithmetic shift
	assign alt = instr.r.funct7[5];

	// kept apart so the shift stays signed
	assign sra_val = $signed(rs1_val) >>> shamt;

	// compares shared by slt/sltu and the branches
	assign lt_s = $signed(rs1_val) < $signed(op_b);
	assign lt_u = rs1_val < op_b;

	// --------------------------------------------------
	// result
	// --------------------------------------------------
	always_comb
	begin
		case (instr.r.funct3)
			// addi never subtracts, its bit 30 is immediate
			rv_pkg::F3_ADD:  result = (alt && is_reg) ? rs1_val - op_b : rs1_val + op_b;
			rv_pkg::F3_SLL:  result = rs1_val << shamt;
			rv_pkg::F3_SLT:  result = {{(rv_pkg::XLEN-1){1'b0}}, lt_s};
			rv_pkg::F3_SLTU: result = {{(rv_pkg::XLEN-1){1'b0}}, lt_u};
			rv_pkg::F3_XOR:  result = rs1_val ^ op_b;
			// srai keeps funct7 in the upper imm bits too
			rv_pkg::F3_SR:   result = alt ? $unsigned(sra_val) : rs1_val >> shamt;
			rv_pkg::F3_OR:   result = rs1_val | op_b;
			rv_pkg::F3_AND:  result = rs1_val & op_b;
			default:         result = rs1_val + op_b;
		endcase
	end

	// --------------------------------------------------
	// branch decision
	// --------------------------------------------------
	always_comb
	begin
		branch_taken = 1'b0;
		if (instr.b.opcode == rv_pkg::OP_BRANCH)
		begin
			case (instr.b.funct3)
				rv_pkg::F3_BEQ:  branch_taken = (rs1_val == rs2_val);
				rv_pkg::F3_BNE:  branch_taken = (rs1_val != rs2_val);
				rv_pkg::F3_BLT:  branch_taken = lt_s;
				rv_pkg::F3_BGE:  branch_taken = !lt_s;
				rv_pkg::F3_BLTU: branch_taken = lt_u;
				rv_pkg::F3_BGEU: branch_taken = !lt_u;
				// 010/011 are not branches
				default:         branch_taken = 1'b0;
			endcase
		end
	end

endmodule

//--- source/rv_control.sv
`timescale 1ns/10ps

module rv_control #(
	parameter int ADDR_W = 8
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        start,
	output rv_pkg::instr_u              instr,
	input  logic [rv_pkg::XLEN-1:0]     imm,
	input  logic [rv_pkg::XLEN-1:0]     rs1_val,
	input  logic [rv_pkg::XLEN-1:0]     rs2_val,
	input  logic [rv_pkg::XLEN-1:0]     alu_result,
	input  logic                        branch_taken,
	output logic                        rf_we,
	output logic [rv_pkg::XLEN-1:0]     rd_wdata,
	output logic [ADDR_W-1:0]           imem_addr,
	input  logic [rv_pkg::XLEN-1:0]     imem_rdata,
	output logic [ADDR_W-1:0]           dmem_addr,
	output logic [rv_pkg::XLEN-1:0]     dmem_wdata,
	output logic                        dmem_we,
	input  logic [rv_pkg::XLEN-1:0]     dmem_rdata,
	output logic                        done
);

	rv_pkg::ctrl_state_e     state;
	rv_pkg::ctrl_state_e     state_nxt;
	logic [ADDR_W-1:0]       pc;
	logic [ADDR_W-1:0]       pc_seq;
	logic [ADDR_W-1:0]       pc_target;
	rv_pkg::instr_u          ir;
	logic [6:0]              opcode;
	logic [rv_pkg::XLEN-1:0] link_val;
	logic [rv_pkg::XLEN-1:0] wb_val;
	logic                    writes_rd;

	assign instr  = ir;
	assign opcode = ir.r.opcode;

	// word addressed pc with offsets added as-is
	assign pc_seq    = pc + 1'b1;
	assign pc_target = pc + imm[ADDR_W-1:0];
	assign link_val  = {{(rv_pkg::XLEN-ADDR_W){1'b0}}, pc_seq};

	// --------------------------------------------------
	// next state
	// --------------------------------------------------
	always_comb
	begin
		state_nxt = state;
		case (state)
			rv_pkg::ST_IDLE:
				if (start)
					state_nxt = rv_pkg::ST_FETCH;
			rv_pkg::ST_FETCH:
				state_nxt = rv_pkg::ST_LATCH;
			// all-zero word halts the core
			rv_pkg::ST_LATCH:
				if (imem_rdata == '0)
					state_nxt = rv_pkg::ST_DONE;
				else
					state_nxt = rv_pkg::ST_EXEC;
			rv_pkg::ST_EXEC:
				if (opcode == rv_pkg::OP_LOAD)
					state_nxt = rv_pkg::ST_MEM;
				else
					state_nxt = rv_pkg::ST_WB;
			rv_pkg::ST_MEM:
				state_nxt = rv_pkg::ST_WB;
			rv_pkg::ST_WB:
				state_nxt = rv_pkg::ST_FETCH;
			// stays here until reset
			rv_pkg::ST_DONE:
				state_nxt = rv_pkg::ST_DONE;
			default:
				state_nxt = rv_pkg::ST_IDLE;
		endcase
	end

	// --------------------------------------------------
	// state and pc
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= rv_pkg::ST_IDLE;
			pc    <= '0;
		end
		else
		begin
			state <= state_nxt;
			// branch and jal resolve in execute
			if (state == rv_pkg::ST_EXEC)
			begin
				if (opcode == rv_pkg::OP_BRANCH)
					pc <= branch_taken ? pc_target : pc_seq;
				else if (opcode == rv_pkg::OP_JAL)
					pc <= pc_target;
			end
			// everything else steps in writeback
			else if (state == rv_pkg::ST_WB)
			begin
				if (opcode != rv_pkg::OP_BRANCH && opcode != rv_pkg::OP_JAL)
					pc <= pc_seq;
			end
		end
	end

	// instruction register and writeback value
	always_ff @(posedge clk)
	begin
		if (state == rv_pkg::ST_LATCH)
			ir <= imem_rdata;
		if (state == rv_pkg::ST_EXEC)
			wb_val <= (opcode == rv_pkg::OP_JAL) ? link_val : alu_result;
		// load data replaces the address sum
		if (state == rv_pkg::ST_MEM)
			wb_val <= dmem_rdata;
	end

	// --------------------------------------------------
	// outputs
	// --------------------------------------------------
	// imem reads one cycle after fetch presents pc
	assign imem_addr = pc;

	// held through execute and memory
	assign dmem_addr  = rs1_val[ADDR_W-1:0] + imm[ADDR_W-1:0];
	assign dmem_wdata = rs2_val;
	assign dmem_we    = (state == rv_pkg::ST_EXEC) && (opcode == rv_pkg::OP_STORE);

	// only result-producing opcodes write rd
	assign writes_rd = opcode inside {rv_pkg::OP_REG, rv_pkg::OP_IMM,
		rv_pkg::OP_JAL, rv_pkg::OP_LOAD};
	assign rf_we    = (state == rv_pkg::ST_WB) && writes_rd;
	assign rd_wdata = wb_val;

	assign done = (state == rv_pkg::ST_DONE);

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	// store strobe sits in the execute slot right after the latch
	a_we_in_exec: assert property (
		@(posedge clk) disable iff (!rst)
		dmem_we |-> $past(state) == rv_pkg::ST_LATCH
	);

	// store strobe never stretches into a second cycle
	a_we_single: assert property (
		@(posedge clk) disable iff (!rst)
		dmem_we |=> !dmem_we
	);

	a_state_legal: assert property (
		@(posedge clk) disable iff (!rst)
		state inside {rv_pkg::ST_IDLE, rv_pkg::ST_FETCH, rv_pkg::ST_LATCH,
			rv_pkg::ST_EXEC, rv_pkg::ST_MEM, rv_pkg::ST_WB, rv_pkg::ST_DONE}
	);

endmodule

//--- source/rv_core.sv
`timescale 1ns/10ps

module rv_core #(
	parameter int ADDR_W = 8
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        start,
	output logic [ADDR_W-1:0]           imem_addr,
	input  logic [rv_pkg::XLEN-1:0]     imem_rdata,
	output logic [ADDR_W-1:0]           dmem_addr,
	output logic [rv_pkg::XLEN-1:0]     dmem_wdata,
	output logic                        dmem_we,
	input  logic [rv_pkg::XLEN-1:0]     dmem_rdata,
	output logic                        done
);

	rv_pkg::instr_u                instr;
	logic [rv_pkg::REG_AW-1:0]     rs1_idx;
	logic [rv_pkg::REG_AW-1:0]     rs2_idx;
	logic [rv_pkg::REG_AW-1:0]     rd_idx;
	logic [rv_pkg::XLEN-1:0]       imm;
	logic [rv_pkg::XLEN-1:0]       rs1_val;
	logic [rv_pkg::XLEN-1:0]       rs2_val;
	logic [rv_pkg::XLEN-1:0]       alu_result;
	logic [rv_pkg::XLEN-1:0]       rd_wdata;
	logic                          branch_taken;
	logic                          rf_we;

	// sequencer, pc and memory strobes
	rv_control #(
		.ADDR_W (ADDR_W)
	) u_control (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.instr        (instr),
		.imm          (imm),
		.rs1_val      (rs1_val),
		.rs2_val      (rs2_val),
		.alu_result   (alu_result),
		.branch_taken (branch_taken),
		.rf_we        (rf_we),
		.rd_wdata     (rd_wdata),
		.imem_addr    (imem_addr),
		.imem_rdata   (imem_rdata),
		.dmem_addr    (dmem_addr),
		.dmem_wdata   (dmem_wdata),
		.dmem_we      (dmem_we),
		.dmem_rdata   (dmem_rdata),
		.done         (done)
	);

	rv_decode u_decode (
		.instr   (instr),
		.rs1_idx (rs1_idx),
		.rs2_idx (rs2_idx),
		.rd_idx  (rd_idx),
		.imm     (imm)
	);

	rv_regfile u_regfile (
		.clk     (clk),
		.rst     (rst),
		.rs1_idx (rs1_idx),
		.rs2_idx (rs2_idx),
		.rd_idx  (rd_idx),
		.we      (rf_we),
		.wdata   (rd_wdata),
		.rs1_val (rs1_val),
		.rs2_val (rs2_val)
	);

	rv_alu u_alu (
		.instr        (instr),
		.rs1_val      (rs1_val),
		.rs2_val      (rs2_val),
		.imm          (imm),
		.result       (alu_result),
		.branch_taken (branch_taken)
	);

endmodule

//--- tests/rv_core_tests.svh
`ifndef RV_CORE_TESTS_SVH
`define RV_CORE_TESTS_SVH

// --------------------------------------------------
// encoders, offsets in words
// --------------------------------------------------
function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
	input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
	return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
endfunction

function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
	input logic [4:0] rs1, input logic [11:0] imm);
	return {imm, rs1, f3, rd, rv_pkg::OP_IMM};
endfunction

function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [4:0] rs1,
	input logic [11:0] imm);
	return {imm, rs1, 3'b010, rd, rv_pkg::OP_LOAD};
endfunction

function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
	input logic [11:0] imm);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OP_STORE};
endfunction

// bit 0 of the offset is dropped by the format, so offsets stay even
function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
	input logic [4:0] rs2, input logic [12:0] off);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OP_BRANCH};
endfunction

function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
	return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OP_JAL};
endfunction

// --------------------------------------------------
// reference rules
// --------------------------------------------------
// op index: add sub sll slt sltu xor srl sra or and
function automatic logic [2:0] alu_f3(input int k);
	case (k)
		0, 1:    return rv_pkg::F3_ADD;
		2:       return rv_pkg::F3_SLL;
		3:       return rv_pkg::F3_SLT;
		4:       return rv_pkg::F3_SLTU;
		5:       return rv_pkg::F3_XOR;
		6, 7:    return rv_pkg::F3_SR;
		8:       return rv_pkg::F3_OR;
		default: return rv_pkg::F3_AND;
	endcase
endfunction

function automatic logic [6:0] alu_f7(input int k);
	return (k == 1 || k == 7) ? 7'b0100000 : 7'b0000000;
endfunction

function automatic logic [31:0] alu_expect(input int k, input logic [31:0] x,
	input logic [31:0] y);
	logic signed [31:0] sx;
	sx = x;
	case (k)
		0:       return x + y;
		1:       return x - y;
		2:       return x << y[4:0];
		3:       return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
		4:       return (x < y) ? 32'd1 : 32'd0;
		5:       return x ^ y;
		6:       return x >> y[4:0];
		7:       return sx >>> y[4:0];
		8:       return x | y;
		default: return x & y;
	endcase
endfunction

// branch index: beq bne blt bge bltu bgeu
function automatic logic [2:0] branch_f3(input int k);
	case (k)
		0:       return rv_pkg::F3_BEQ;
		1:       return rv_pkg::F3_BNE;
		2:       return rv_pkg::F3_BLT;
		3:       return rv_pkg::F3_BGE;
		4:       return rv_pkg::F3_BLTU;
		default: return rv_pkg::F3_BGEU;
	endcase
endfunction

function automatic logic branch_expect(input int k, input logic [31:0] x,
	input logic [31:0] y);
	case (k)
		0:       return x == y;
		1:       return x != y;
		2:       return $signed(x) < $signed(y);
		3:       return $signed(x) >= $signed(y);
		4:       return x < y;
		default: return x >= y;
	endcase
endfunction

// untouched data words, tagged with their own address
function automatic logic [31:0] fill_word(input int a);
	return 32'hdead_0000 | (a & (DEPTH - 1));
endfunction

// --------------------------------------------------
// program loading and run control
// --------------------------------------------------
task automatic clear_memories();
	for (int a = 0; a < DEPTH; a++)
	begin
		imem[a] = '0;
		dmem[a] = fill_word(a);
	end
	load_pc = 0;
endtask

task automatic emit(input logic [31:0] word);
	imem[load_pc] = word;
	load_pc++;
endtask

// reset, start pulse, then wait for the halt
task automatic run_program();
	@(negedge clk);
	rst   = 1'b0;
	start = 1'b0;
	repeat (16) @(negedge clk);
	rst = 1'b1;
	@(negedge clk);
	start = 1'b1;
	@(negedge clk);
	start = 1'b0;
	while (done !== 1'b1)
		@(negedge clk);
endtask

task automatic report_mismatch(input string name, input logic [31:0] got,
	input logic [31:0] exp);
	$display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
	errors++;
endtask

task automatic finish_test(input string name, input int errs_before);
	if (errors == errs_before)
	begin
		$display("%s: passed", name);
		n_pass++;
	end
	else
	begin
		$display("%s: failed with %0d mismatches", name, errors - errs_before);
		n_fail++;
	end
endtask

// --------------------------------------------------
// directed tests
// --------------------------------------------------
task automatic register_alu();
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] exp;
	int errs;
	errs = errors;
	a    = $random(seed);
	b    = $random(seed);
	clear_memories();
	dmem[0] = a;
	dmem[1] = b;
	emit(load_word(5'd1, 5'd0, 12'd0));
	emit(load_word(5'd2, 5'd0, 12'd1));
	// each result to its own register and slot
	for (int k = 0; k < 10; k++)
	begin
		emit(r_type(alu_f7(k), alu_f3(k), 5'(k + 3), 5'd1, 5'd2));
		emit(store_word(5'(k + 3), 5'd0, 12'(16 + k)));
	end
	emit('0);
	run_program();
	for (int k = 0; k < 10; k++)
	begin
		exp = alu_expect(k, a, b);
		if (dmem[16 + k] !== exp)
			report_mismatch($sformatf("dmem[%0d]", 16 + k), dmem[16 + k], exp);
	end
	finish_test("register alu", errs);
endtask

task automatic immediate_alu();
	logic [31:0] a;
	logic [31:0] r;
	logic [31:0] exp;
	logic [31:0] opb [9];
	logic [11:0] imm;
	int ops [9];
	int errs;
	errs = errors;
	// negative source so srai has sign bits to shift in
	a = $random(seed) | 32'h8000_0000;
	clear_memories();
	dmem[0] = a;
	emit(load_word(5'd1, 5'd0, 12'd0));
	for (int i = 0; i < 9; i++)
	begin
		// no subi, skip index 1
		ops[i] = (i == 0) ? 0 : i + 1;
		r      = $random(seed);
		if (ops[i] == 2 || ops[i] == 6 || ops[i] == 7)
		begin
			imm    = {alu_f7(ops[i]), r[4:0]};
			opb[i] = {27'd0, r[4:0]};
		end
		else
		begin
			imm = r[11:0];
			// slti and sltiu see a negative immediate
			if (ops[i] == 3 || ops[i] == 4)
				imm[11] = 1'b1;
			opb[i] = {{20{imm[11]}}, imm};
		end
		emit(i_type(alu_f3(ops[i]), 5'(i + 3), 5'd1, imm));
		emit(store_word(5'(i + 3), 5'd0, 12'(16 + i)));
	end
	emit('0);
	run_program();
	for (int i = 0; i < 9; i++)
	begin
		exp = alu_expect(ops[i], a, opb[i]);
		if (dmem[16 + i] !== exp)
			report_mismatch($sformatf("dmem[%0d]", 16 + i), dmem[16 + i], exp);
	end
	finish_test("immediate alu", errs);
endtask

task automatic branch_paths();
	// operand order per branch: 0 is x1,x2  1 is x2,x1  2 is x1,x1
	int first_pick [6] = '{2, 0, 0, 1, 1, 0};
	int second_pick [6] = '{0, 2, 1, 0, 0, 1};
	logic [31:0] exp [12];
	logic [31:0] xa;
	logic [31:0] xb;
	logic [4:0] rs1;
	logic [4:0] rs2;
	int k;
	int v;
	int errs;
	errs = errors;
	clear_memories();
	emit(i_type(rv_pkg::F3_ADD, 5'd1, 5'd0, 12'hffb));
	emit(i_type(rv_pkg::F3_ADD, 5'd2, 5'd0, 12'd7));
	emit(i_type(rv_pkg::F3_ADD, 5'd5, 5'd0, 12'd1));
	emit(i_type(rv_pkg::F3_ADD, 5'd6, 5'd0, 12'd2));
	for (int c = 0; c < 12; c++)
	begin
		k   = c / 2;
		v   = (c % 2 == 0) ? first_pick[k] : second_pick[k];
		rs1 = (v == 1) ? 5'd2 : 5'd1;
		rs2 = (v == 0) ? 5'd2 : 5'd1;
		// x1 holds -5, x2 holds 7
		xa  = (rs1 == 5'd1) ? 32'hffff_fffb : 32'd7;
		xb  = (rs2 == 5'd1) ? 32'hffff_fffb : 32'd7;
		exp[c] = branch_expect(k, xa, xb) ? 32'd2 : 32'd1;
		// six word block, marker 1 on fall-through, 2 at the target
		emit(branch_word(branch_f3(k), rs1, rs2, 13'd4));
		emit(store_word(5'd5, 5'd0, 12'(32 + c)));
		emit(jal_word(5'd0, 21'd4));
		emit(i_type(rv_pkg::F3_ADD, 5'd0, 5'd0, 12'd0));
		emit(store_word(5'd6, 5'd0, 12'(32 + c)));
		emit(i_type(rv_pkg::F3_ADD, 5'd0, 5'd0, 12'd0));
	end
	emit('0);
	run_program();
	for (int c = 0; c < 12; c++)
	begin
		if (dmem[32 + c] !== exp[c])
			report_mismatch($sformatf("dmem[%0d]", 32 + c), dmem[32 + c], exp[c]);
	end
	finish_test("branches", errs);
endtask

task automatic jal_link();
	int jal_at;
	int errs;
	errs   = errors;
	jal_at = 19;
	clear_memories();
	emit(i_type(rv_pkg::F3_ADD, 5'd5, 5'd0, 12'd3));
	// forward hop over a store that must not run
	emit(jal_word(5'd0, 21'(jal_at - 1)));
	emit(store_word(5'd5, 5'd0, 12'd41));
	load_pc = jal_at;
	emit(jal_word(5'd1, 21'd4));
	emit(store_word(5'd5, 5'd0, 12'd41));
	emit(store_word(5'd5, 5'd0, 12'd41));
	emit(i_type(rv_pkg::F3_ADD, 5'd0, 5'd0, 12'd0));
	emit(store_word(5'd1, 5'd0, 12'd40));
	emit('0);
	run_program();
	if (dmem[40] !== 32'(jal_at + 1))
		report_mismatch("dmem[40]", dmem[40], 32'(jal_at + 1));
	if (dmem[41] !== fill_word(41))
		report_mismatch("dmem[41]", dmem[41], fill_word(41));
	finish_test("jal", errs);
endtask

task automatic load_store_x0();
	logic [31:0] w;
	int errs;
	errs = errors;
	w    = $random(seed);
	clear_memories();
	dmem[50] = w;
	emit(load_word(5'd3, 5'd0, 12'd50));
	emit(store_word(5'd3, 5'd0, 12'd51));
	// base register plus negative offset lands on 58
	emit(i_type(rv_pkg::F3_ADD, 5'd4, 5'd0, 12'd60));
	emit(store_word(5'd3, 5'd4, 12'hffe));
	emit(i_type(rv_pkg::F3_ADD, 5'd0, 5'd0, 12'd123));
	emit(store_word(5'd0, 5'd0, 12'd52));
	emit(load_word(5'd0, 5'd0, 12'd50));
	emit(store_word(5'd0, 5'd0, 12'd53));
	emit('0);
	run_program();
	if (dmem[50] !== w)
		report_mismatch("dmem[50]", dmem[50], w);
	if (dmem[51] !== w)
		report_mismatch("dmem[51]", dmem[51], w);
	if (dmem[58] !== w)
		report_mismatch("dmem[58]", dmem[58], w);
	if (dmem[52] !== 32'd0)
		report_mismatch("dmem[52]", dmem[52], 32'd0);
	if (dmem[53] !== 32'd0)
		report_mismatch("dmem[53]", dmem[53], 32'd0);
	finish_test("load store and x0", errs);
endtask

task automatic halt_hold();
	logic [ADDR_W-1:0] held;
	int halt_at;
	int errs;
	errs    = errors;
	halt_at = 2;
	clear_memories();
	emit(i_type(rv_pkg::F3_ADD, 5'd1, 5'd0, 12'd9));
	emit(store_word(5'd1, 5'd0, 12'd60));
	emit('0);
	run_program();
	held = imem_addr;
	if (dmem[60] !== 32'd9)
		report_mismatch("dmem[60]", dmem[60], 32'd9);
	if (held !== ADDR_W'(halt_at))
		report_mismatch("imem_addr", 32'(held), 32'(halt_at));
	// core must sit still after the zero word
	repeat (20)
	begin
		@(negedge clk);
		if (done !== 1'b1)
			report_mismatch("done", 32'(done), 32'd1);
		if (dmem_we !== 1'b0)
			report_mismatch("dmem_we", 32'(dmem_we), 32'd0);
		if (imem_addr !== held)
			report_mismatch("imem_addr", 32'(imem_addr), 32'(held));
	end
	finish_test("halt", errs);
endtask

`endif

//--- tests/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;

	localparam int ADDR_W = 8;
	localparam int DEPTH  = 2**ADDR_W;
	// six tests of 16 reset cycles and up to 40 five-cycle instructions, plus slack
	localparam int CYCLE_LIMIT = 6 * (16 + 40 * 5) + 200;

	logic              clk;
	logic              rst;
	logic              start;
	logic [ADDR_W-1:0] imem_addr;
	logic [31:0]       imem_rdata;
	logic [ADDR_W-1:0] dmem_addr;
	logic [31:0]       dmem_wdata;
	logic              dmem_we;
	logic [31:0]       dmem_rdata;
	logic              done;

	// behavioural memories, word addressed
	logic [31:0] imem [DEPTH];
	logic [31:0] dmem [DEPTH];

	int seed;
	int errors;
	int n_pass;
	int n_fail;
	int load_pc;
	int cycles;

	rv_core #(
		.ADDR_W (ADDR_W)
	) u_rv_core (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_rdata (dmem_rdata),
		.done       (done)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	// --------------------------------------------------
	// memory models
	// --------------------------------------------------
	// read data valid one cycle after the address
	always @(posedge clk)
	begin
		imem_rdata <= imem[imem_addr];
		dmem_rdata <= dmem[dmem_addr];
		if (dmem_we)
			dmem[dmem_addr] <= dmem_wdata;
	end

	// run length guard
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: the core did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	`include "rv_core_tests.svh"

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial
	begin
		clk        = 1'b0;
		rst        = 1'b0;
		start      = 1'b0;
		imem_rdata = '0;
		dmem_rdata = '0;
		seed       = 28233;
		errors     = 0;
		n_pass     = 0;
		n_fail     = 0;
		load_pc    = 0;
		cycles     = 0;

		register_alu();
		immediate_alu();
		branch_paths();
		jal_link();
		load_store_x0();
		halt_hold();

		$display("tests passed %0d, failed %0d, mismatches %0d", n_pass, n_fail, errors);
		if (n_fail == 0 && errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- src.f
+incdir+tests
source/rv_pkg.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_control.sv
source/rv_core.sv
tests/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - source/rv_pkg.sv
  - source/rv_decode.sv
  - source/rv_regfile.sv
  - source/rv_alu.sv
  - source/rv_control.sv
  - source/rv_core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_rv_core.sv
